// File: files.f
design/dcache_pkg.sv
design/dcache_ctrl_pe.sv
design/dcache_memctrl.sv
design/dcache_miss_apb.sv
design/dcache_ctrl.sv
dv/tb_apb_mem.sv
dv/tb_dcache_ctrl.sv

// File: dv/tb_dcache_ctrl.sv
`timescale 1ns/1ps
/* Data cache testbench: clock, reset, LCG stimulus, memory and directory
   model, compare tasks, watchdog and summary */
module tb_dcache_ctrl;
    localparam int SETS        = 16;
    localparam int LINE_WORDS  = 4;
    localparam int N_REQ       = 300;
    localparam int OFF_W       = $clog2(LINE_WORDS) + 2;
    localparam int SET_W       = $clog2(SETS);
    localparam int MEM_WORDS   = 2 ** (dcache_pkg::ADDR_W - 2);
    localparam dcache_pkg::addr_t ERR_BASE = 16'hF000;
    // Worst case per request is a full sweep or a refill with long stalls
    localparam int WATCHDOG_NS = (N_REQ * (SETS + 8 * LINE_WORDS + 8) + 100) * 4;

    typedef struct packed {
        dcache_pkg::data_t rdata;
        dcache_pkg::tid_t  tid;
        logic              err;
        logic              hit;
        logic              miss;
        logic [31:0]       cycle;
    } exp_t;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                req_valid;
    logic                req_ready;
    dcache_pkg::req_op_e req_op;
    dcache_pkg::addr_t   req_addr;
    dcache_pkg::data_t   req_wdata;
    dcache_pkg::be_t     req_be;
    dcache_pkg::tid_t    req_tid;
    logic                rsp_valid;
    dcache_pkg::data_t   rsp_rdata;
    dcache_pkg::tid_t    rsp_tid;
    logic                rsp_error;
    logic                psel;
    logic                penable;
    logic                pwrite;
    dcache_pkg::addr_t   paddr;
    dcache_pkg::data_t   pwdata;
    dcache_pkg::be_t     pstrb;
    logic                pready;
    dcache_pkg::data_t   prdata;
    logic                pslverr;
    logic                evt_miss;
    logic                ctrl_empty;
    logic                apb_wait;

    logic [31:0]         seed;
    dcache_pkg::data_t   mem_model [MEM_WORDS];
    logic                dir_valid [SETS];
    dcache_pkg::addr_t   dir_tag   [SETS];
    exp_t                exp_q [$];
    int                  errors;
    int                  issued;
    int                  evt_cnt;
    int unsigned         cycle;
    logic                accepted;

    always #2 clk = ~clk;

    dcache_ctrl #(
        .SETS       (SETS),
        .LINE_WORDS (LINE_WORDS)
    ) u_dcache_ctrl (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .core_req_valid_i (req_valid),
        .core_req_ready_o (req_ready),
        .core_req_op_i    (req_op),
        .core_req_addr_i  (req_addr),
        .core_req_wdata_i (req_wdata),
        .core_req_be_i    (req_be),
        .core_req_tid_i   (req_tid),
        .core_rsp_valid_o (rsp_valid),
        .core_rsp_rdata_o (rsp_rdata),
        .core_rsp_tid_o   (rsp_tid),
        .core_rsp_error_o (rsp_error),
        .apb_psel_o       (psel),
        .apb_penable_o    (penable),
        .apb_pwrite_o     (pwrite),
        .apb_paddr_o      (paddr),
        .apb_pwdata_o     (pwdata),
        .apb_pstrb_o      (pstrb),
        .apb_pready_i     (pready),
        .apb_prdata_i     (prdata),
        .apb_pslverr_i    (pslverr),
        .evt_read_miss_o  (evt_miss),
        .ctrl_empty_o     (ctrl_empty)
    );

    tb_apb_mem #(
        .ERR_BASE (ERR_BASE)
    ) u_mem (
        .clk_i     (clk),
        .wait_i    (apb_wait),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .pstrb_i   (pstrb),
        .pready_o  (pready),
        .prdata_o  (prdata),
        .pslverr_o (pslverr)
    );

    // Upper LCG bits land in the low half of the result
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[15:0], seed[31:16]};
    endfunction

    // Two tags over four sets plus an occasional error-region word
    function automatic dcache_pkg::addr_t rand_addr();
        logic [31:0] r;
        int unsigned tag;
        int unsigned set_i;
        int unsigned word_i;
        r = next_rand();
        if (r[7:4] == 4'hf) begin
            return ERR_BASE + dcache_pkg::addr_t'({r[17:10], 2'b00});
        end
        tag    = 1 + r[2];
        set_i  = r[1:0];
        word_i = r[9:8] % LINE_WORDS;
        return dcache_pkg::addr_t'((tag << (OFF_W + SET_W)) | (set_i << OFF_W) | (word_i << 2));
    endfunction

    task automatic check_data(input string name, input dcache_pkg::data_t exp,
                              input dcache_pkg::data_t act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_tid(input string name, input dcache_pkg::tid_t exp,
                             input dcache_pkg::tid_t act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected %0d, actual %0d at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected %b, actual %b at %0t", name, exp, act, $time);
        end
    endtask

    // Applies the request to the model in order and queues its response
    task automatic accept_request();
        exp_t              e;
        int unsigned       set_i;
        int unsigned       w;
        dcache_pkg::addr_t tag;
        logic              hit;
        logic              bad;
        set_i = (req_addr >> OFF_W) % SETS;
        tag   = req_addr >> (OFF_W + SET_W);
        w     = req_addr >> 2;
        hit   = dir_valid[set_i] && (dir_tag[set_i] == tag);
        bad   = req_addr >= ERR_BASE;
        e       = '0;
        e.tid   = req_tid;
        e.cycle = cycle;
        e.err   = bad && (req_op != dcache_pkg::OP_INVAL_ALL);
        case (req_op)
            dcache_pkg::OP_LOAD: begin
                e.hit   = hit;
                e.miss  = !hit;
                e.rdata = bad ? '0 : mem_model[w];
                if (!hit) begin
                    // A refill that erred leaves the set empty
                    dir_valid[set_i] = !bad;
                    dir_tag[set_i]   = tag;
                end
            end
            dcache_pkg::OP_STORE: begin
                for (int b = 0; b < dcache_pkg::DATA_W / 8; b++) begin
                    if (req_be[b] && !bad) begin
                        mem_model[w][8*b +: 8] = req_wdata[8*b +: 8];
                    end
                end
            end
            default: begin
                for (int s = 0; s < SETS; s++) begin
                    dir_valid[s] = 1'b0;
                end
            end
        endcase
        exp_q.push_back(e);
    endtask

    task automatic match_response();
        exp_t e;
        if (exp_q.size() == 0) begin
            errors++;
            $display("Response with tid %0d arrived with no request outstanding", rsp_tid);
        end else begin
            e = exp_q.pop_front();
            check_tid("rsp_tid", e.tid, rsp_tid);
            check_data("rsp_rdata", e.rdata, rsp_rdata);
            check_flag("rsp_error", e.err, rsp_error);
            check_data("read_miss_events", dcache_pkg::data_t'(e.miss),
                       dcache_pkg::data_t'(evt_cnt));
            if (e.hit) begin
                check_flag("hit_latency", 1'b1, cycle == e.cycle + 1);
            end
        end
        evt_cnt = 0;
    endtask

    task automatic drive_cycle();
        logic [31:0] r;
        @(posedge clk);
        #1;
        r        = next_rand();
        apb_wait = (r[1:0] == 2'b00);
        if (!req_valid || accepted) begin
            req_valid = 1'b0;
            if (issued < N_REQ && r[4:2] != 3'd0) begin
                r         = next_rand();
                req_op    = (r[3:0] == 4'd0) ? dcache_pkg::OP_INVAL_ALL :
                            (r[3:0] < 4'd5) ? dcache_pkg::OP_STORE : dcache_pkg::OP_LOAD;
                req_be    = r[7:4];
                req_tid   = r[11:8];
                req_addr  = rand_addr();
                req_wdata = next_rand();
                req_valid = 1'b1;
                issued++;
            end
        end
    endtask

    task automatic sample_cycle();
        @(negedge clk);
        cycle++;
        check_flag("ctrl_empty", exp_q.size() == 0, ctrl_empty);
        if (evt_miss) begin
            evt_cnt++;
        end
        if (rsp_valid) begin
            match_response();
        end
        accepted = req_valid && req_ready;
        if (accepted) begin
            accept_request();
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

    initial begin
        seed      = 32'h82df_80a7;
        errors    = 0;
        issued    = 0;
        evt_cnt   = 0;
        cycle     = 0;
        accepted  = 1'b0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_op    = dcache_pkg::OP_LOAD;
        req_addr  = '0;
        req_wdata = '0;
        req_be    = '0;
        req_tid   = '0;
        apb_wait  = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model[i] = next_rand();
            u_mem.mem[i] = mem_model[i];
        end
        for (int s = 0; s < SETS; s++) begin
            dir_valid[s] = 1'b0;
            dir_tag[s]   = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Directory sweep keeps ready low for one cycle per set
        for (int i = 0; i < SETS; i++) begin
            @(negedge clk);
            check_flag("reset_ready", 1'b0, req_ready);
            check_flag("reset_rsp_valid", 1'b0, rsp_valid);
            check_flag("reset_psel", 1'b0, psel);
            check_flag("reset_penable", 1'b0, penable);
        end
        @(negedge clk);
        check_flag("reset_ready", 1'b1, req_ready);
        while (issued < N_REQ || req_valid || exp_q.size() != 0) begin
            drive_cycle();
            sample_cycle();
        end
        repeat (4) begin
            drive_cycle();
            sample_cycle();
        end
        $display("Requests: %0d, errors: %0d", issued, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: dv/tb_apb_mem.sv
`timescale 1ns/1ps
/* APB slave memory with externally chosen wait states
   and an error region that answers pslverr and drops writes */
module tb_apb_mem #(
    parameter dcache_pkg::addr_t ERR_BASE = 16'hF000
) (
    input  logic              clk_i,
    input  logic              wait_i,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  dcache_pkg::addr_t paddr_i,
    input  dcache_pkg::data_t pwdata_i,
    input  dcache_pkg::be_t   pstrb_i,
    output logic              pready_o,
    output dcache_pkg::data_t prdata_o,
    output logic              pslverr_o
);
    localparam int WORDS = 2 ** (dcache_pkg::ADDR_W - 2);

    dcache_pkg::data_t mem [WORDS];
    logic              in_err;

    assign in_err    = paddr_i >= ERR_BASE;
    assign pready_o  = psel_i && penable_i && !wait_i;
    assign pslverr_o = pready_o && in_err;
    // Erroring reads return zero
    assign prdata_o  = (pready_o && !pwrite_i && !in_err) ?
                       mem[paddr_i[dcache_pkg::ADDR_W-1:2]] : '0;

    always @(posedge clk_i) begin
        if (pready_o && pwrite_i && !in_err) begin
            for (int b = 0; b < dcache_pkg::DATA_W / 8; b++) begin
                if (pstrb_i[b]) begin
                    mem[paddr_i[dcache_pkg::ADDR_W-1:2]][8*b +: 8] <= pwdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: design/dcache_ctrl.sv
`timescale 1ns/1ps
/* Data cache controller top: stage-1 request registers, response mux,
   protocol engine, array controller and APB miss unit */
module dcache_ctrl #(
    parameter int SETS       = 16,
    parameter int LINE_WORDS = 4
) (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  logic                core_req_valid_i,
    output logic                core_req_ready_o,
    input  dcache_pkg::req_op_e core_req_op_i,
    input  dcache_pkg::addr_t   core_req_addr_i,
    input  dcache_pkg::data_t   core_req_wdata_i,
    input  dcache_pkg::be_t     core_req_be_i,
    input  dcache_pkg::tid_t    core_req_tid_i,

    output logic                core_rsp_valid_o,
    output dcache_pkg::data_t   core_rsp_rdata_o,
    output dcache_pkg::tid_t    core_rsp_tid_o,
    output logic                core_rsp_error_o,

    output logic                apb_psel_o,
    output logic                apb_penable_o,
    output logic                apb_pwrite_o,
    output dcache_pkg::addr_t   apb_paddr_o,
    output dcache_pkg::data_t   apb_pwdata_o,
    output dcache_pkg::be_t     apb_pstrb_o,
    input  logic                apb_pready_i,
    input  dcache_pkg::data_t   apb_prdata_i,
    input  logic                apb_pslverr_i,

    output logic                evt_read_miss_o,
    output logic                ctrl_empty_o
);
    localparam int WORD_W = $clog2(LINE_WORDS);

    dcache_pkg::req_op_e st1_op_q;
    dcache_pkg::addr_t   st1_addr_q;
    dcache_pkg::data_t   st1_wdata_q;
    dcache_pkg::be_t     st1_be_q;
    dcache_pkg::tid_t    st1_tid_q;

    logic              st1_valid;
    logic              accept;
    logic              array_write;
    logic              dir_hit;
    logic              sweep_busy;
    logic              line_req;
    logic              word_req;
    logic              inval_req;
    logic              refill_write;
    logic              refill_dir_write;
    logic [WORD_W-1:0] refill_word;
    dcache_pkg::data_t refill_data;
    dcache_pkg::data_t array_rdata;
    dcache_pkg::data_t miss_rdata;
    logic              miss_done;
    logic              miss_error;

    // Stage-1 payload held until the next acceptance
    always_ff @(posedge clk_i) begin
        if (accept) begin
            st1_op_q    <= core_req_op_i;
            st1_addr_q  <= core_req_addr_i;
            st1_wdata_q <= core_req_wdata_i;
            st1_be_q    <= core_req_be_i;
            st1_tid_q   <= core_req_tid_i;
        end
    end

    dcache_ctrl_pe u_pe (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .core_req_valid_i (core_req_valid_i),
        .st1_op_i         (st1_op_q),
        .dir_hit_i        (dir_hit),
        .sweep_busy_i     (sweep_busy),
        .miss_done_i      (miss_done),
        .core_req_ready_o (core_req_ready_o),
        .st1_valid_o      (st1_valid),
        .core_rsp_valid_o (core_rsp_valid_o),
        .array_read_o     (accept),
        .array_write_o    (array_write),
        .line_req_o       (line_req),
        .word_req_o       (word_req),
        .inval_req_o      (inval_req),
        .evt_read_miss_o  (evt_read_miss_o)
    );

    dcache_memctrl #(
        .SETS       (SETS),
        .LINE_WORDS (LINE_WORDS)
    ) u_memctrl (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .read_i             (accept),
        .read_addr_i        (core_req_addr_i),
        .st1_addr_i         (st1_addr_q),
        .write_i            (array_write),
        .write_data_i       (st1_wdata_q),
        .write_be_i         (st1_be_q),
        .refill_write_i     (refill_write),
        .refill_word_i      (refill_word),
        .refill_data_i      (refill_data),
        .refill_dir_write_i (refill_dir_write),
        .inval_all_i        (inval_req),
        .hit_o              (dir_hit),
        .rdata_o            (array_rdata),
        .sweep_busy_o       (sweep_busy)
    );

    dcache_miss_apb #(
        .LINE_WORDS (LINE_WORDS)
    ) u_miss_apb (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .line_req_i         (line_req),
        .word_req_i         (word_req),
        .addr_i             (st1_addr_q),
        .wdata_i            (st1_wdata_q),
        .be_i               (st1_be_q),
        .apb_psel_o         (apb_psel_o),
        .apb_penable_o      (apb_penable_o),
        .apb_pwrite_o       (apb_pwrite_o),
        .apb_paddr_o        (apb_paddr_o),
        .apb_pwdata_o       (apb_pwdata_o),
        .apb_pstrb_o        (apb_pstrb_o),
        .apb_pready_i       (apb_pready_i),
        .apb_prdata_i       (apb_prdata_i),
        .apb_pslverr_i      (apb_pslverr_i),
        .refill_write_o     (refill_write),
        .refill_word_o      (refill_word),
        .refill_data_o      (refill_data),
        .refill_dir_write_o (refill_dir_write),
        .done_o             (miss_done),
        .rdata_o            (miss_rdata),
        .error_o            (miss_error)
    );

    // Only loads return data; a finished refill overrides the array word
    assign core_rsp_rdata_o = (st1_op_q != dcache_pkg::OP_LOAD) ? '0 :
                              (miss_done ? miss_rdata : array_rdata);
    assign core_rsp_tid_o   = st1_tid_q;
    assign core_rsp_error_o = miss_done & miss_error;

    // The engine always sits in PE_RUN when stage 1 is empty
    assign ctrl_empty_o = ~st1_valid;

    // Payload holds until its request is answered
    st1_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        st1_valid && !core_rsp_valid_o
        |=> $stable({st1_op_q, st1_addr_q, st1_wdata_q, st1_be_q, st1_tid_q}));

endmodule

// File: design/dcache_miss_apb.sv
`timescale 1ns/1ps
/* APB master for line refills and single-word write-through stores */
module dcache_miss_apb #(
    parameter int LINE_WORDS = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          line_req_i,
    input  logic                          word_req_i,
    input  dcache_pkg::addr_t             addr_i,
    input  dcache_pkg::data_t             wdata_i,
    input  dcache_pkg::be_t               be_i,

    output logic                          apb_psel_o,
    output logic                          apb_penable_o,
    output logic                          apb_pwrite_o,
    output dcache_pkg::addr_t             apb_paddr_o,
    output dcache_pkg::data_t             apb_pwdata_o,
    output dcache_pkg::be_t               apb_pstrb_o,
    input  logic                          apb_pready_i,
    input  dcache_pkg::data_t             apb_prdata_i,
    input  logic                          apb_pslverr_i,

    output logic                          refill_write_o,
    output logic [$clog2(LINE_WORDS)-1:0] refill_word_o,
    output dcache_pkg::data_t             refill_data_o,
    output logic                          refill_dir_write_o,
    output logic                          done_o,
    output dcache_pkg::data_t             rdata_o,
    output logic                          error_o
);
    localparam int WORD_W = $clog2(LINE_WORDS);
    localparam int OFF_W  = WORD_W + 2;

    dcache_pkg::apb_state_e state_q;
    logic                   is_write_q;
    logic [WORD_W-1:0]      beat_q;
    logic                   err_q;
    logic                   done_q;
    dcache_pkg::data_t      rdata_q;
    logic                   beat_done;
    logic                   last_beat;

    assign beat_done = (state_q == dcache_pkg::APB_ACCESS) && apb_pready_i;
    assign last_beat = is_write_q || (beat_q == WORD_W'(LINE_WORDS - 1));

    assign apb_psel_o    = state_q != dcache_pkg::APB_IDLE;
    assign apb_penable_o = state_q == dcache_pkg::APB_ACCESS;
    assign apb_pwrite_o  = is_write_q;
    // Refills walk the line from word 0
    assign apb_paddr_o   = is_write_q ? {addr_i[dcache_pkg::ADDR_W-1:2], 2'b00} :
                           {addr_i[dcache_pkg::ADDR_W-1:OFF_W], beat_q, 2'b00};
    assign apb_pwdata_o  = wdata_i;
    assign apb_pstrb_o   = is_write_q ? be_i : '0;

    assign refill_write_o     = beat_done && !is_write_q;
    assign refill_word_o      = beat_q;
    assign refill_data_o      = apb_prdata_i;
    assign refill_dir_write_o = refill_write_o && last_beat && !(err_q || apb_pslverr_i);

    assign done_o  = done_q;
    assign rdata_o = rdata_q;
    assign error_o = err_q;

    // Keep the word the load asked for
    always_ff @(posedge clk_i) begin
        if (refill_write_o && (beat_q == addr_i[2 +: WORD_W])) begin
            rdata_q <= apb_prdata_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= dcache_pkg::APB_IDLE;
            is_write_q <= 1'b0;
            beat_q     <= '0;
            err_q      <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            done_q <= beat_done && last_beat;
            unique case (state_q)
                dcache_pkg::APB_IDLE: begin
                    if (line_req_i || word_req_i) begin
                        state_q    <= dcache_pkg::APB_SETUP;
                        is_write_q <= word_req_i;
                        beat_q     <= '0;
                        err_q      <= 1'b0;
                    end
                end
                dcache_pkg::APB_SETUP: begin
                    state_q <= dcache_pkg::APB_ACCESS;
                end
                dcache_pkg::APB_ACCESS: begin
                    if (apb_pready_i) begin
                        err_q   <= err_q | apb_pslverr_i;
                        beat_q  <= beat_q + 1'b1;
                        state_q <= last_beat ? dcache_pkg::APB_IDLE : dcache_pkg::APB_SETUP;
                    end
                end
                default: begin
                    state_q <= dcache_pkg::APB_IDLE;
                end
            endcase
        end
    end

    penable_psel_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        apb_penable_o |-> apb_psel_o);

    paddr_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        apb_penable_o && !apb_pready_i |=> $stable(apb_paddr_o));

endmodule

// File: design/dcache_memctrl.sv
`timescale 1ns/1ps
/* Directory and data arrays, stage-1 tag compare,
   store and refill writes, reset and invalidate-all sweep */
module dcache_memctrl #(
    parameter int SETS       = 16,
    parameter int LINE_WORDS = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          read_i,
    input  dcache_pkg::addr_t             read_addr_i,
    input  dcache_pkg::addr_t             st1_addr_i,
    input  logic                          write_i,
    input  dcache_pkg::data_t             write_data_i,
    input  dcache_pkg::be_t               write_be_i,
    input  logic                          refill_write_i,
    input  logic [$clog2(LINE_WORDS)-1:0] refill_word_i,
    input  dcache_pkg::data_t             refill_data_i,
    input  logic                          refill_dir_write_i,
    input  logic                          inval_all_i,
    output logic                          hit_o,
    output dcache_pkg::data_t             rdata_o,
    output logic                          sweep_busy_o
);
    localparam int SET_W  = $clog2(SETS);
    localparam int WORD_W = $clog2(LINE_WORDS);
    localparam int OFF_W  = WORD_W + 2;
    localparam int TAG_W  = dcache_pkg::ADDR_W - SET_W - OFF_W;

    logic              valid_mem [SETS];
    logic [TAG_W-1:0]  tag_mem   [SETS];
    dcache_pkg::data_t data_mem  [SETS*LINE_WORDS];

    logic              rd_valid_q;
    logic [TAG_W-1:0]  rd_tag_q;
    dcache_pkg::data_t rd_data_q;
    logic              sweep_busy_q;
    logic [SET_W-1:0]  sweep_set_q;

    logic [SET_W-1:0]  rd_set;
    logic [WORD_W-1:0] rd_word;
    logic [SET_W-1:0]  wr_set;
    logic [WORD_W-1:0] wr_word;
    logic [TAG_W-1:0]  st1_tag;

    assign rd_set  = read_addr_i[OFF_W +: SET_W];
    assign rd_word = read_addr_i[2 +: WORD_W];
    assign wr_set  = st1_addr_i[OFF_W +: SET_W];
    assign wr_word = st1_addr_i[2 +: WORD_W];
    assign st1_tag = st1_addr_i[dcache_pkg::ADDR_W-1 -: TAG_W];

    // Stage 0 read of both arrays
    always_ff @(posedge clk_i) begin
        if (read_i) begin
            rd_valid_q <= valid_mem[rd_set];
            rd_tag_q   <= tag_mem[rd_set];
            rd_data_q  <= data_mem[{rd_set, rd_word}];
        end
    end

    // Refill beats drop the old line until the final beat validates the new one
    always_ff @(posedge clk_i) begin
        if (sweep_busy_q) begin
            valid_mem[sweep_set_q] <= 1'b0;
        end else if (refill_dir_write_i) begin
            valid_mem[wr_set] <= 1'b1;
            tag_mem[wr_set]   <= st1_tag;
        end else if (refill_write_i) begin
            valid_mem[wr_set] <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (refill_write_i) begin
            data_mem[{wr_set, refill_word_i}] <= refill_data_i;
        end else if (write_i) begin
            for (int b = 0; b < dcache_pkg::DATA_W / 8; b++) begin
                if (write_be_i[b]) begin
                    data_mem[{wr_set, wr_word}][8*b +: 8] <= write_data_i[8*b +: 8];
                end
            end
        end
    end

    // One set cleared per cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sweep_busy_q <= 1'b1;
            sweep_set_q  <= '0;
        end else if (inval_all_i) begin
            sweep_busy_q <= 1'b1;
            sweep_set_q  <= '0;
        end else if (sweep_busy_q) begin
            sweep_set_q <= sweep_set_q + 1'b1;
            if (sweep_set_q == SET_W'(SETS - 1)) begin
                sweep_busy_q <= 1'b0;
            end
        end
    end

    assign hit_o        = rd_valid_q && (rd_tag_q == st1_tag);
    assign rdata_o      = rd_data_q;
    assign sweep_busy_o = sweep_busy_q;

    no_write_in_sweep_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        sweep_busy_o |-> !(write_i || refill_write_i || refill_dir_write_i));

endmodule

// File: design/dcache_ctrl_pe.sv
`timescale 1ns/1ps
/* Protocol engine: request acceptance, hit responses and
   miss, store and invalidate-all sequencing */
module dcache_ctrl_pe (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  logic                core_req_valid_i,
    input  dcache_pkg::req_op_e st1_op_i,
    input  logic                dir_hit_i,
    input  logic                sweep_busy_i,
    input  logic                miss_done_i,

    output logic                core_req_ready_o,
    output logic                st1_valid_o,
    output logic                core_rsp_valid_o,
    output logic                array_read_o,
    output logic                array_write_o,
    output logic                line_req_o,
    output logic                word_req_o,
    output logic                inval_req_o,
    output logic                evt_read_miss_o
);
    dcache_pkg::pe_state_e state_q;
    dcache_pkg::pe_state_e state_d;
    logic                  st1_valid_q;
    logic                  store_hit_q;
    logic                  st1_load_hit;

    assign st1_load_hit = st1_valid_q && (st1_op_i == dcache_pkg::OP_LOAD) && dir_hit_i;

    always_comb begin
        state_d          = state_q;
        core_req_ready_o = 1'b0;
        core_rsp_valid_o = 1'b0;
        array_write_o    = 1'b0;
        line_req_o       = 1'b0;
        word_req_o       = 1'b0;
        inval_req_o      = 1'b0;
        unique case (state_q)
            dcache_pkg::PE_RUN: begin
                // A load hit leaves stage 1 this cycle, so the next one may enter
                core_req_ready_o = !sweep_busy_i && (!st1_valid_q || st1_load_hit);
                if (st1_valid_q) begin
                    unique case (st1_op_i)
                        dcache_pkg::OP_LOAD: begin
                            if (dir_hit_i) begin
                                core_rsp_valid_o = 1'b1;
                            end else begin
                                line_req_o = 1'b1;
                                state_d    = dcache_pkg::PE_MISS;
                            end
                        end
                        dcache_pkg::OP_STORE: begin
                            word_req_o = 1'b1;
                            state_d    = dcache_pkg::PE_STORE;
                        end
                        default: begin
                            inval_req_o = 1'b1;
                            state_d     = dcache_pkg::PE_INVAL;
                        end
                    endcase
                end
            end
            dcache_pkg::PE_MISS: begin
                if (miss_done_i) begin
                    core_rsp_valid_o = 1'b1;
                    core_req_ready_o = 1'b1;
                    state_d          = dcache_pkg::PE_RUN;
                end
            end
            dcache_pkg::PE_STORE: begin
                if (miss_done_i) begin
                    core_rsp_valid_o = 1'b1;
                    array_write_o    = store_hit_q;
                    state_d          = dcache_pkg::PE_RUN;
                end
            end
            default: begin
                if (!sweep_busy_i) begin
                    core_rsp_valid_o = 1'b1;
                    state_d          = dcache_pkg::PE_RUN;
                end
            end
        endcase
    end

    assign array_read_o    = core_req_valid_i && core_req_ready_o;
    assign st1_valid_o     = st1_valid_q;
    assign evt_read_miss_o = line_req_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= dcache_pkg::PE_RUN;
            st1_valid_q <= 1'b0;
            store_hit_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            st1_valid_q <= array_read_o || (st1_valid_q && !core_rsp_valid_o);
            if (word_req_o) begin
                store_hit_q <= dir_hit_i;
            end
        end
    end

    // Requests are only ever accepted into PE_RUN
    ready_run_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_req_ready_o |=> state_q == dcache_pkg::PE_RUN);

    one_start_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({line_req_o, word_req_o, inval_req_o}));

endmodule

// File: design/dcache_pkg.sv
/* Widths, data types, request opcodes and FSM state encodings
   shared by the data cache RTL and its testbench */
package dcache_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [DATA_W/8-1:0] be_t;
    typedef logic [3:0]          tid_t;

    typedef enum logic [1:0] {
        OP_LOAD      = 2'd0,
        OP_STORE     = 2'd1,
        OP_INVAL_ALL = 2'd2
    } req_op_e;

    // Protocol engine
    typedef enum logic [1:0] {
        PE_RUN   = 2'd0,
        PE_MISS  = 2'd1,
        PE_STORE = 2'd2,
        PE_INVAL = 2'd3
    } pe_state_e;

    // APB master
    typedef enum logic [1:0] {
        APB_IDLE   = 2'd0,
        APB_SETUP  = 2'd1,
        APB_ACCESS = 2'd2
    } apb_state_e;

endpackage
